// File: design/fetch_pkg.sv
/*
  fetch package
  shared widths, parcel queue sizing, reset PC and the RV32 opcode
  and funct constants used by the instruction fetch unit
*/
package fetch_pkg;

  ///////////////////////////////
  // widths
  ///////////////////////////////
  localparam int unsigned XLEN             = 32;
  localparam int unsigned PARCEL_W         = 16;
  localparam int unsigned PARCELS_PER_WORD = XLEN / PARCEL_W;  // 2

  typedef logic [XLEN-1:0]     xlen_t;    // address or data word
  typedef logic [PARCEL_W-1:0] parcel_t;  // one 16-bit parcel
  typedef logic [31:0]         insn_t;    // one full instruction

  ///////////////////////////////
  // queue sizing
  ///////////////////////////////
  // max outstanding fetches on the memory side
  localparam int unsigned INFLIGHT_CNT   = 2;

  // depth in parcels
  localparam int unsigned QUEUE_DEPTH    = 3 * INFLIGHT_CNT * PARCELS_PER_WORD;

  // stop requesting here, leaves room for the words still in flight
  localparam int unsigned FULL_THRESHOLD =
    QUEUE_DEPTH - (INFLIGHT_CNT + 1) * PARCELS_PER_WORD;

  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_cnt_t;

  localparam xlen_t PC_INIT = 32'h0000_0200;  // reset PC

  ///////////////////////////////
  // instruction words
  ///////////////////////////////
  localparam insn_t INSN_NOP     = 32'h0000_0013;  // addi x0,x0,0
  localparam insn_t INSN_WFI     = 32'h1050_0073;
  localparam insn_t INSN_ILLEGAL = 32'h0000_0000;

  // major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3
  localparam logic [2:0] F3_ADDI = 3'b000;
  localparam logic [2:0] F3_SLLI = 3'b001;
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SUB  = 3'b000;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7
  localparam logic [6:0] F7_ADD  = 7'b0000000;  // also xor, or, and
  localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

// File: design/fetch_addr_gen.sv
/*
  fetch address generator
  holds the linear fetch address, steps it one word per accepted
  request and reloads it on a branch redirect
*/
`timescale 1ns/1ps

module fetch_addr_gen
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             bu_flush_i,     // redirect strobe
  input  fetch_pkg::xlen_t bu_nxt_pc_i,    // redirect target
  input  logic             queue_full_i,
  input  logic             imem_ack_i,
  output fetch_pkg::xlen_t imem_adr_o,
  output logic             imem_req_o,
  output logic             imem_flush_o
);

  fetch_pkg::xlen_t adr_seq;  // address + one word

  // no new fetches while the queue is full or the stream is redirected
  assign imem_req_o   = ~queue_full_i & ~bu_flush_i;
  assign imem_flush_o = bu_flush_i;

  assign adr_seq = imem_adr_o + 32'd4;

  // sequential fetches are word aligned but a redirect target may not be
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      imem_adr_o <= fetch_pkg::PC_INIT;
    else if (bu_flush_i)
      imem_adr_o <= bu_nxt_pc_i;
    else if (imem_req_o && imem_ack_i)
      imem_adr_o <= {adr_seq[31:2], 2'b00};
  end

  ///////////////////////////////
  // checks
  ///////////////////////////////
  // an accepted fetch moves on to the next word boundary
  a_seq_step: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    imem_req_o && imem_ack_i |=>
      imem_adr_o[1:0] == 2'b00 &&
      (imem_adr_o - $past(imem_adr_o) == 32'd4 || imem_adr_o - $past(imem_adr_o) == 32'd2)
  ) else $error("accepted fetch did not step to the next word");

endmodule

// File: design/parcel_queue.sv
/*
  parcel queue
  shift-register queue of 16-bit instruction parcels. each cycle the
  popped parcels shift out and the valid incoming parcels are appended,
  low parcel first. reports fill level for the request logic
*/
`timescale 1ns/1ps

module parcel_queue
(
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    flush_i,
  input  fetch_pkg::xlen_t                        parcel_i,
  input  logic [fetch_pkg::PARCELS_PER_WORD-1:0]  parcel_valid_i,
  input  logic                                    pop_one_i,
  input  logic                                    pop_two_i,
  output fetch_pkg::insn_t                        head_o,        // two oldest parcels
  output logic                                    head_valid_o,  // at least one parcel
  output logic                                    pair_valid_o,  // at least two parcels
  output logic                                    full_o
);

  localparam int unsigned DEPTH = fetch_pkg::QUEUE_DEPTH;

  fetch_pkg::parcel_t    q     [DEPTH];      // parcel storage, entry 0 is the head
  fetch_pkg::parcel_t    q_win [DEPTH+2];    // storage padded for the shift
  fetch_pkg::parcel_t    q_nxt [DEPTH];
  fetch_pkg::queue_cnt_t cnt;
  fetch_pkg::queue_cnt_t cnt_nxt;
  fetch_pkg::queue_cnt_t cnt_shift;          // fill after the pop
  fetch_pkg::queue_cnt_t pop_cnt;
  fetch_pkg::queue_cnt_t lo_slot;
  fetch_pkg::queue_cnt_t hi_slot;

  assign pop_cnt = pop_two_i ? fetch_pkg::queue_cnt_t'(2) : {3'b000, pop_one_i};

  assign cnt_shift = cnt - pop_cnt;
  assign lo_slot   = cnt_shift;
  assign hi_slot   = cnt_shift + {3'b000, parcel_valid_i[0]};  // high parcel follows low

  ///////////////////////////////
  // next queue contents
  ///////////////////////////////
  always_comb
  begin
    for (int i = 0; i < DEPTH + 2; i++)
      q_win[i] = (i < DEPTH) ? q[i] : '0;

    for (int i = 0; i < DEPTH; i++)
    begin
      // shift out popped parcels
      if (pop_two_i)
        q_nxt[i] = q_win[i+2];
      else if (pop_one_i)
        q_nxt[i] = q_win[i+1];
      else
        q_nxt[i] = q_win[i];

      // append incoming parcels behind the remaining ones
      if (parcel_valid_i[0] && fetch_pkg::queue_cnt_t'(i) == lo_slot)
        q_nxt[i] = parcel_i[15:0];
      if (parcel_valid_i[1] && fetch_pkg::queue_cnt_t'(i) == hi_slot)
        q_nxt[i] = parcel_i[31:16];
    end
  end

  always_comb
  begin
    if (flush_i)
      cnt_nxt = '0;  // same-cycle input dropped too
    else
      cnt_nxt = cnt_shift + {3'b000, parcel_valid_i[0]} + {3'b000, parcel_valid_i[1]};
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cnt <= '0;
    else
      cnt <= cnt_nxt;
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < DEPTH; i++)
      q[i] <= q_nxt[i];
  end

  assign head_o       = {q[1], q[0]};
  assign head_valid_o = (cnt != '0);
  assign pair_valid_o = (cnt >= fetch_pkg::queue_cnt_t'(2));
  assign full_o       = (cnt >= fetch_pkg::queue_cnt_t'(fetch_pkg::FULL_THRESHOLD));

  ///////////////////////////////
  // checks
  ///////////////////////////////
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnt <= fetch_pkg::queue_cnt_t'(DEPTH)
  ) else $error("parcel queue overflow");

  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (pop_two_i |-> cnt >= fetch_pkg::queue_cnt_t'(2)) and (pop_one_i |-> cnt != '0)
  ) else $error("parcel queue popped past its fill level");

endmodule

// File: design/rvc_expander.sv
/*
  RVC expander
  builds the 32-bit form of the supported compressed instructions,
  every other or reserved parcel becomes the illegal word.
  32-bit instructions pass through with WFI replaced by a NOP
*/
`timescale 1ns/1ps

module rvc_expander
(
  input  fetch_pkg::parcel_t parcel_i,
  input  fetch_pkg::insn_t   insn32_i,
  input  logic               is_rvc_i,
  output fetch_pkg::insn_t   insn_o
);

  // op-imm, I-type layout
  function automatic fetch_pkg::insn_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, fetch_pkg::OPC_OP_IMM};
  endfunction

  // register-register, R-type layout
  function automatic fetch_pkg::insn_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, fetch_pkg::OPC_OP};
  endfunction

  logic [4:0]       rd_full;     // rd/rs1 field, bits 11:7
  logic [4:0]       rs2_full;    // rs2 field, bits 6:2
  logic [4:0]       rd_prime;    // x8..x15
  logic [4:0]       rs2_prime;
  logic [5:0]       imm6;        // CI immediate
  logic [11:0]      imm_ci;
  logic [19:0]      imm_lui;
  fetch_pkg::insn_t rvc_insn;

  assign rd_full   = parcel_i[11:7];
  assign rs2_full  = parcel_i[6:2];
  assign rd_prime  = {2'b01, parcel_i[9:7]};
  assign rs2_prime = {2'b01, parcel_i[4:2]};
  assign imm6      = {parcel_i[12], parcel_i[6:2]};
  assign imm_ci    = {{6{imm6[5]}}, imm6};
  assign imm_lui   = {{14{imm6[5]}}, imm6};

  always_comb
  begin
    rvc_insn = fetch_pkg::INSN_ILLEGAL;  // unsupported and reserved forms
    case ({parcel_i[15:13], parcel_i[1:0]})
      5'b000_01:  // C.NOP / C.ADDI
        rvc_insn = (rd_full == 5'd0) ? fetch_pkg::INSN_NOP
                                     : enc_i(imm_ci, rd_full, fetch_pkg::F3_ADDI, rd_full);
      5'b010_01:  // C.LI
        if (rd_full != 5'd0)
          rvc_insn = enc_i(imm_ci, 5'd0, fetch_pkg::F3_ADDI, rd_full);
      5'b011_01:  // C.LUI, rd=2 would be ADDI16SP
        if (rd_full != 5'd0 && rd_full != 5'd2 && imm6 != 6'd0)
          rvc_insn = {imm_lui, rd_full, fetch_pkg::OPC_LUI};
      5'b100_01:  // register ALU group, bit 12 set means W forms
        if (parcel_i[12:10] == 3'b011)
        begin
          case (parcel_i[6:5])
            2'b00: rvc_insn = enc_r(fetch_pkg::F7_SUB, rs2_prime, rd_prime,
                                    fetch_pkg::F3_SUB, rd_prime);
            2'b01: rvc_insn = enc_r(fetch_pkg::F7_ADD, rs2_prime, rd_prime,
                                    fetch_pkg::F3_XOR, rd_prime);
            2'b10: rvc_insn = enc_r(fetch_pkg::F7_ADD, rs2_prime, rd_prime,
                                    fetch_pkg::F3_OR, rd_prime);
            default: rvc_insn = enc_r(fetch_pkg::F7_ADD, rs2_prime, rd_prime,
                                      fetch_pkg::F3_AND, rd_prime);
          endcase
        end
      5'b000_10:  // C.SLLI, shamt[5] lands in imm bit 5
        rvc_insn = enc_i({6'b000000, imm6}, rd_full, fetch_pkg::F3_SLLI, rd_full);
      5'b100_10:  // C.MV / C.ADD, rs2=0 are jumps and ebreak
        if (rs2_full != 5'd0)
        begin
          if (parcel_i[12])
            rvc_insn = enc_r(fetch_pkg::F7_ADD, rs2_full, rd_full, fetch_pkg::F3_ADD, rd_full);
          else if (rd_full != 5'd0)
            rvc_insn = enc_r(fetch_pkg::F7_ADD, rs2_full, 5'd0, fetch_pkg::F3_ADD, rd_full);
        end
      default: ;
    endcase
  end

  always_comb
  begin
    if (is_rvc_i)
      insn_o = rvc_insn;
    else if (insn32_i == fetch_pkg::INSN_WFI)
      insn_o = fetch_pkg::INSN_NOP;  // wfi runs as a nop
    else
      insn_o = insn32_i;
  end

endmodule

// File: design/fetch_issue.sv
/*
  fetch issue stage
  decodes the length of the head instruction, pops its parcels,
  tracks PC and next-PC and registers the instruction and bubble
  for the pre-decode stage
*/
`timescale 1ns/1ps

module fetch_issue
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             bu_flush_i,
  input  fetch_pkg::xlen_t bu_nxt_pc_i,
  input  logic             pd_stall_i,
  input  fetch_pkg::insn_t head_i,
  input  logic             head_valid_i,
  input  logic             pair_valid_i,
  output logic             pop_one_o,
  output logic             pop_two_o,
  output fetch_pkg::xlen_t if_pc_o,
  output fetch_pkg::xlen_t if_nxt_pc_o,
  output fetch_pkg::insn_t if_insn_o,
  output logic             if_bubble_o
);

  logic             is_16bit;
  logic             insn_avail;  // all parcels of the head present
  logic             issue;
  fetch_pkg::insn_t nxt_insn;

  ///////////////////////////////
  // length decode and pop
  ///////////////////////////////
  assign is_16bit   = ~&head_i[1:0];
  assign insn_avail = head_valid_i & (is_16bit | pair_valid_i);
  assign issue      = insn_avail & ~pd_stall_i & ~bu_flush_i;

  assign pop_one_o = issue & is_16bit;
  assign pop_two_o = issue & ~is_16bit;

  rvc_expander u_rvc_expander
  (
    .parcel_i ( head_i[15:0] ),
    .insn32_i ( head_i       ),
    .is_rvc_i ( is_16bit     ),
    .insn_o   ( nxt_insn     )
  );

  ///////////////////////////////
  // outputs
  ///////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      if_nxt_pc_o <= fetch_pkg::PC_INIT;
    else if (bu_flush_i)
      if_nxt_pc_o <= bu_nxt_pc_i;
    else if (issue)
      if_nxt_pc_o <= if_nxt_pc_o + (is_16bit ? 32'd2 : 32'd4);
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      if_pc_o   <= fetch_pkg::PC_INIT;
      if_insn_o <= fetch_pkg::INSN_NOP;
    end
    else if (issue)
    begin
      if_pc_o   <= if_nxt_pc_o;  // pc of the popped instruction
      if_insn_o <= nxt_insn;
    end
  end

  // bubble holds while stalled and is forced on a redirect
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      if_bubble_o <= 1'b1;
    else if (bu_flush_i)
      if_bubble_o <= 1'b1;
    else if (!pd_stall_i)
      if_bubble_o <= ~insn_avail;
  end

  // a shown instruction is 2 or 4 bytes long
  a_nxt_pc_step: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !if_bubble_o |-> (if_nxt_pc_o - if_pc_o == 32'd2) || (if_nxt_pc_o - if_pc_o == 32'd4)
  ) else $error("next pc is not one instruction past pc");

endmodule

// File: design/instr_fetch.sv
/*
  RV32 instruction fetch unit, top level
  address generator, parcel queue and issue stage with RVC expansion
*/
`timescale 1ns/1ps

module instr_fetch
(
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // instruction memory
  output fetch_pkg::xlen_t                       imem_adr_o,
  output logic                                   imem_req_o,
  input  logic                                   imem_ack_i,
  output logic                                   imem_flush_o,
  input  fetch_pkg::xlen_t                       imem_parcel_i,
  input  logic [fetch_pkg::PARCELS_PER_WORD-1:0] imem_parcel_valid_i,
  // redirect and back-pressure
  input  logic                                   bu_flush_i,
  input  fetch_pkg::xlen_t                       bu_nxt_pc_i,
  input  logic                                   pd_stall_i,
  // to pre-decode
  output fetch_pkg::xlen_t                       if_pc_o,
  output fetch_pkg::xlen_t                       if_nxt_pc_o,
  output fetch_pkg::insn_t                       if_insn_o,
  output logic                                   if_bubble_o
);

  logic             queue_full;
  logic             head_valid;
  logic             pair_valid;
  logic             pop_one;
  logic             pop_two;
  fetch_pkg::insn_t head;

  fetch_addr_gen u_addr_gen
  (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .bu_flush_i   ( bu_flush_i   ),
    .bu_nxt_pc_i  ( bu_nxt_pc_i  ),
    .queue_full_i ( queue_full   ),
    .imem_ack_i   ( imem_ack_i   ),
    .imem_adr_o   ( imem_adr_o   ),
    .imem_req_o   ( imem_req_o   ),
    .imem_flush_o ( imem_flush_o )
  );

  parcel_queue u_parcel_queue
  (
    .clk_i          ( clk_i               ),
    .rst_ni         ( rst_ni              ),
    .flush_i        ( imem_flush_o        ),  // drops responses in the redirect cycle
    .parcel_i       ( imem_parcel_i       ),
    .parcel_valid_i ( imem_parcel_valid_i ),
    .pop_one_i      ( pop_one             ),
    .pop_two_i      ( pop_two             ),
    .head_o         ( head                ),
    .head_valid_o   ( head_valid          ),
    .pair_valid_o   ( pair_valid          ),
    .full_o         ( queue_full          )
  );

  fetch_issue u_issue
  (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .bu_flush_i   ( bu_flush_i  ),
    .bu_nxt_pc_i  ( bu_nxt_pc_i ),
    .pd_stall_i   ( pd_stall_i  ),
    .head_i       ( head        ),
    .head_valid_i ( head_valid  ),
    .pair_valid_i ( pair_valid  ),
    .pop_one_o    ( pop_one     ),
    .pop_two_o    ( pop_two     ),
    .if_pc_o      ( if_pc_o     ),
    .if_nxt_pc_o  ( if_nxt_pc_o ),
    .if_insn_o    ( if_insn_o   ),
    .if_bubble_o  ( if_bubble_o )
  );

endmodule

// File: tests/fetch_tb.sv
/*
  instruction fetch testbench
  drives a random RV32/RVC program with random ack, stall and redirect
  stimulus and compares the outputs with a reference decode
*/
`timescale 1ns/1ps

module fetch_tb;

  logic             clk_i;
  logic             rst_ni;
  fetch_pkg::xlen_t imem_adr_o;
  logic             imem_req_o;
  logic             imem_ack_i;
  logic             imem_flush_o;
  fetch_pkg::xlen_t imem_parcel_i       = '0;
  logic [1:0]       imem_parcel_valid_i = '0;
  logic             bu_flush_i;
  fetch_pkg::xlen_t bu_nxt_pc_i;
  logic             pd_stall_i;
  fetch_pkg::xlen_t if_pc_o;
  fetch_pkg::xlen_t if_nxt_pc_o;
  fetch_pkg::insn_t if_insn_o;
  logic             if_bubble_o;

  fetch_pkg::xlen_t mem [1024];           // addresses wrap at 4 KB
  logic [15:0]      lfsr_q;
  logic             acc_q     = 1'b0;     // fetch accepted on the last edge
  fetch_pkg::xlen_t acc_adr_q = '0;
  fetch_pkg::xlen_t exp_pc    = fetch_pkg::PC_INIT;
  int               consumed  = 0;
  int               stall_left = 0;
  logic             req_drop_seen = 1'b0;
  logic             held_q = 1'b0;        // outputs must repeat this cycle
  fetch_pkg::xlen_t pc_q;
  fetch_pkg::xlen_t nxt_q;
  fetch_pkg::insn_t insn_q;
  logic             bubble_q;

  instr_fetch dut_i
  (
    .clk_i               ( clk_i               ),
    .rst_ni              ( rst_ni              ),
    .imem_adr_o          ( imem_adr_o          ),
    .imem_req_o          ( imem_req_o          ),
    .imem_ack_i          ( imem_ack_i          ),
    .imem_flush_o        ( imem_flush_o        ),
    .imem_parcel_i       ( imem_parcel_i       ),
    .imem_parcel_valid_i ( imem_parcel_valid_i ),
    .bu_flush_i          ( bu_flush_i          ),
    .bu_nxt_pc_i         ( bu_nxt_pc_i         ),
    .pd_stall_i          ( pd_stall_i          ),
    .if_pc_o             ( if_pc_o             ),
    .if_nxt_pc_o         ( if_nxt_pc_o         ),
    .if_insn_o           ( if_insn_o           ),
    .if_bubble_o         ( if_bubble_o         )
  );

  always #10 clk_i = ~clk_i;

  // 16-bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [15:0] parcel_at(input fetch_pkg::xlen_t pc);
    fetch_pkg::xlen_t w;
    w = mem[pc[11:2]];
    return pc[1] ? w[31:16] : w[15:0];
  endfunction

  ///////////////////////////////
  // reference decode
  ///////////////////////////////
  function automatic fetch_pkg::insn_t expand_rvc(input logic [15:0] c);
    logic [4:0]       rd;
    logic [4:0]       rs2;
    logic [4:0]       rdp;
    logic [4:0]       rs2p;
    logic [11:0]      imm;
    fetch_pkg::insn_t r;
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = {2'b01, c[9:7]};   // x8..x15
    rs2p = {2'b01, c[4:2]};
    imm  = {{7{c[12]}}, c[6:2]};
    r    = fetch_pkg::INSN_ILLEGAL;
    if (c[1:0] == 2'b01 && c[15:13] == 3'b000)                      // c.nop, c.addi
      r = (rd == 5'd0) ? fetch_pkg::INSN_NOP : {imm, rd, 3'b000, rd, 7'h13};
    else if (c[1:0] == 2'b01 && c[15:13] == 3'b010 && rd != 5'd0)  // c.li
      r = {imm, 5'd0, 3'b000, rd, 7'h13};
    else if (c[1:0] == 2'b01 && c[15:13] == 3'b011 && rd != 5'd0 && rd != 5'd2
             && imm != 12'd0)                                      // c.lui
      r = {{8{c[12]}}, imm, rd, 7'h37};
    else if (c[1:0] == 2'b01 && c[15:10] == 6'b100011)
    begin
      case (c[6:5])
        2'b00:   r = {7'h20, rs2p, rdp, 3'b000, rdp, 7'h33};
        2'b01:   r = {7'h00, rs2p, rdp, 3'b100, rdp, 7'h33};
        2'b10:   r = {7'h00, rs2p, rdp, 3'b110, rdp, 7'h33};
        default: r = {7'h00, rs2p, rdp, 3'b111, rdp, 7'h33};
      endcase
    end
    else if (c[1:0] == 2'b10 && c[15:13] == 3'b000)                 // c.slli
      r = {6'd0, c[12], c[6:2], rd, 3'b001, rd, 7'h13};
    else if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && rs2 != 5'd0 && (c[12] || rd != 5'd0))
      r = {7'h00, rs2, c[12] ? rd : 5'd0, 3'b000, rd, 7'h33};     // c.add, c.mv
    return r;
  endfunction

  function automatic fetch_pkg::insn_t ref_insn(input fetch_pkg::xlen_t pc);
    logic [15:0]      lo;
    fetch_pkg::insn_t w;
    lo = parcel_at(pc);
    w  = {parcel_at(pc + 32'd2), lo};
    if (lo[1:0] != 2'b11)
      w = expand_rvc(lo);
    else if (w == fetch_pkg::INSN_WFI)
      w = fetch_pkg::INSN_NOP;
    return w;
  endfunction

  function automatic fetch_pkg::xlen_t insn_len(input fetch_pkg::xlen_t pc);
    logic [15:0] lo;
    lo = parcel_at(pc);
    return (lo[1:0] == 2'b11) ? 32'd4 : 32'd2;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
      report_failure($sformatf("MISMATCH %s got %08h expected %08h", name, got, exp));
  endtask

  task automatic check_next_insn();
    check_value("if_pc_o", if_pc_o, exp_pc);
    check_value("if_insn_o", if_insn_o, ref_insn(exp_pc));
    check_value("if_nxt_pc_o", if_nxt_pc_o, exp_pc + insn_len(exp_pc));
    exp_pc = exp_pc + insn_len(exp_pc);
    consumed++;
  endtask

  // random mix of kept rvc, dropped rvc, wfi and plain 32-bit words
  task automatic fill_memory();
    int          p;
    logic [31:0] k;
    logic [31:0] w;
    logic [15:0] c;
    p = 0;
    while (p < 2048)
    begin
      k = rand_bits(4);
      w = rand_bits(30);
      case (k[3:0])
        4'd0:    c = 16'h0001;
        4'd1:    c = {3'b000, w[10:0], 2'b01};
        4'd2:    c = {3'b010, w[10:0], 2'b01};
        4'd3:    c = {3'b011, w[10:0], 2'b01};
        4'd4:    c = {3'b100, w[10:0], 2'b10};
        4'd5:    c = {3'b000, w[10:0], 2'b10};
        4'd6:    c = {6'b100011, w[7:0], 2'b01};
        4'd7:    c = {w[13:0], 2'b00};
        4'd8:    c = {w[13:0], 2'b01};
        4'd9:    c = {w[13:0], 2'b10};
        default: c = 16'h0003;  // 32-bit below
      endcase
      if (k[3:0] >= 4'd10)
      begin
        w = (k[3:0] == 4'd10) ? fetch_pkg::INSN_WFI : {w[29:0], 2'b11};
        mem[(p / 2) % 1024][16 * (p % 2) +: 16]           = w[15:0];
        mem[((p + 1) / 2) % 1024][16 * ((p + 1) % 2) +: 16] = w[31:16];
        p += 2;
      end
      else
      begin
        mem[(p / 2) % 1024][16 * (p % 2) +: 16] = c;
        p++;
      end
    end
  endtask

  ///////////////////////////////
  // memory model with one cycle latency
  ///////////////////////////////
  always @(posedge clk_i)
  begin
    acc_q     <= rst_ni && imem_req_o && imem_ack_i;
    acc_adr_q <= imem_adr_o;
  end

  always @(negedge clk_i)
  begin
    imem_parcel_i       = acc_q ? mem[acc_adr_q[11:2]] : '0;
    imem_parcel_valid_i = acc_q ? {1'b1, ~acc_adr_q[1]} : 2'b00;  // low parcel skipped if unaligned
  end

  // each instruction is counted in its first unstalled cycle
  always @(posedge clk_i)
  begin
    if (rst_ni)
    begin
      if (held_q)
      begin
        check_value("if_pc_o", if_pc_o, pc_q);
        check_value("if_nxt_pc_o", if_nxt_pc_o, nxt_q);
        check_value("if_insn_o", if_insn_o, insn_q);
        check_value("if_bubble_o", {31'd0, if_bubble_o}, {31'd0, bubble_q});
      end
      check_value("imem_flush_o", {31'd0, imem_flush_o}, {31'd0, bu_flush_i});
      if (bu_flush_i)
        check_value("imem_req_o", {31'd0, imem_req_o}, 32'd0);
      if (!imem_req_o && !bu_flush_i && pd_stall_i)
        req_drop_seen = 1'b1;
      if (bu_flush_i)
        exp_pc = bu_nxt_pc_i;  // old stream squashed
      else if (!if_bubble_o && !pd_stall_i)
        check_next_insn();
      held_q   = pd_stall_i && !bu_flush_i;
      pc_q     = if_pc_o;
      nxt_q    = if_nxt_pc_o;
      insn_q   = if_insn_o;
      bubble_q = if_bubble_o;
    end
  end

  ///////////////////////////////
  // stimulus
  ///////////////////////////////
  // mode 0 steady, 1 random stall, 2 stall bursts and random ack, 3 random both
  task automatic drive_cycle(input int mode);
    logic [31:0] r;
    @(negedge clk_i);
    r          = rand_bits(3);
    bu_flush_i = 1'b0;
    imem_ack_i = (mode >= 2) ? r[0] : 1'b1;
    if (mode == 0)
      pd_stall_i = 1'b0;
    else if (stall_left > 0)
    begin
      pd_stall_i = 1'b1;
      stall_left--;
    end
    else
    begin
      pd_stall_i = (r[2:1] == 2'b00);
      if (mode == 2 && pd_stall_i)
        stall_left = 8 + int'(rand_bits(3));  // long enough to fill the queue
    end
  endtask

  task automatic redirect_random();
    logic [31:0] r;
    @(negedge clk_i);
    r           = rand_bits(13);
    bu_flush_i  = 1'b1;
    bu_nxt_pc_i = {20'd0, r[10:0], 1'b0};  // bit 1 set half the time
    pd_stall_i  = r[11];
    imem_ack_i  = r[12];
  endtask

  task automatic run_until(input int target, input int max_cycles, input int mode);
    int n;
    n = 0;
    while (consumed < target && n < max_cycles)
    begin
      drive_cycle(mode);
      n++;
    end
    if (consumed < target)
      report_failure($sformatf("timeout: %0d of %0d instructions issued", consumed, target));
  endtask

  initial
  begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    imem_ack_i  = 1'b0;
    bu_flush_i  = 1'b0;
    bu_nxt_pc_i = '0;
    pd_stall_i  = 1'b0;
    lfsr_q      = 16'd91;
    fill_memory();
    repeat (16) @(negedge clk_i);
    check_value("if_bubble_o", {31'd0, if_bubble_o}, 32'd1);
    check_value("if_insn_o", if_insn_o, fetch_pkg::INSN_NOP);
    check_value("if_pc_o", if_pc_o, fetch_pkg::PC_INIT);
    check_value("if_nxt_pc_o", if_nxt_pc_o, fetch_pkg::PC_INIT);
    check_value("imem_adr_o", imem_adr_o, fetch_pkg::PC_INIT);
    rst_ni = 1'b1;

    run_until(200, 3000, 0);
    run_until(600, 8000, 1);
    req_drop_seen = 1'b0;
    run_until(1200, 20000, 2);
    assert (req_drop_seen)
    else
      report_failure("imem_req_o never dropped while the queue was filling");

    repeat (24)
    begin
      redirect_random();
      run_until(consumed + 8, 1000, 3);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: compile.f
design/fetch_pkg.sv
design/fetch_addr_gen.sv
design/parcel_queue.sv
design/rvc_expander.sv
design/fetch_issue.sv
design/instr_fetch.sv
tests/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the instruction fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module fetch_tb \
  -f compile.f -Mdir "$BUILD_DIR" -o fetch_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/fetch_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
  exit 0
fi
exit 1
